/* src/ntrpt_params.svh */
////////////////////////////////////////////////////////////////////////////
// Size and cause-code constants for the interrupt CAM FIFO, included by
// the packages and by every module that sizes an entry array
////////////////////////////////////////////////////////////////////////////
`ifndef NTRPT_PARAMS_SVH
`define NTRPT_PARAMS_SVH

`define FIFO_DEPTH 16
`define DATA_BITS  32
`define CAUSE_BITS 16
`define MTIP_CAUSE 16'h0080

`endif

/* src/fifo_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Storage types of the CAM FIFO: one stored word and the occupancy count
////////////////////////////////////////////////////////////////////////////
`include "ntrpt_params.svh"

package fifo_pkg;

  // One FIFO entry
  typedef logic [`DATA_BITS-1:0] data_t;

  // Valid entry count, 0 up to and including the depth
  typedef logic [$clog2(`FIFO_DEPTH):0] count_t;

endpackage

/* src/ntrpt_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Interrupt-cause types shared by the CAM FIFO match logic
////////////////////////////////////////////////////////////////////////////
`include "ntrpt_params.svh"

package ntrpt_pkg;

  // Cause code carried in the low bits of each stored word
  typedef logic [`CAUSE_BITS-1:0] cause_t;

endpackage

/* src/occupancy_counter.sv */
////////////////////////////////////////////////////////////////////////////
// Occupancy counter of the CAM FIFO; qualifies the raw push and pop
// strobes against full and empty and tracks the number of valid entries
////////////////////////////////////////////////////////////////////////////
`include "ntrpt_params.svh"

module occupancy_counter (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  output fifo_pkg::count_t count,
  output logic             push_ok,
  output logic             pop_ok
);

  logic is_full;
  logic is_empty;

  assign is_full  = (count == fifo_pkg::count_t'(`FIFO_DEPTH));
  assign is_empty = (count == '0);

  // A push on a full FIFO still fits when the same edge removes a word
  assign push_ok = push && (!is_full || (pop && !is_empty));
  assign pop_ok  = pop && !is_empty;

  //////////////////////////////////////////////////////////////////////////
  // Count register
  //////////////////////////////////////////////////////////////////////////

  // The qualified strobes already keep the count inside 0..depth
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          // Push and pop together leave the occupancy as it is
          count <= count;
        end
      endcase
    end
  end

endmodule

/* src/entry_shift_store.sv */
////////////////////////////////////////////////////////////////////////////
// Shift-register entry array of the CAM FIFO; new words enter at entry 0
// and the popped entry is cleared so unused slots always read as zero
////////////////////////////////////////////////////////////////////////////
`include "ntrpt_params.svh"

module entry_shift_store (
  input  logic             clk,
  input  logic             reset,
  input  logic             push_ok,
  input  logic             pop_ok,
  input  fifo_pkg::data_t  din,
  input  fifo_pkg::count_t count,
  output fifo_pkg::data_t  entries [`FIFO_DEPTH]
);

  // Word each entry takes on a shift
  fifo_pkg::data_t shift_in [`FIFO_DEPTH];

  genvar i;
  generate
    for (i = 0; i < `FIFO_DEPTH; i = i + 1) begin : g_entry
      logic clear_on_shift;
      logic clear_in_place;

      if (i == 0) begin : g_head
        assign shift_in[i] = din;
      end else begin : g_body
        assign shift_in[i] = entries[i-1];
      end

      // With a shift the popped word has moved up one slot, to index count
      assign clear_on_shift = pop_ok && (count == fifo_pkg::count_t'(i));
      // Without a shift the oldest word still sits at count-1
      assign clear_in_place = pop_ok && (count == fifo_pkg::count_t'(i + 1));

      always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
          entries[i] <= '0;
        end else if (push_ok) begin
          if (clear_on_shift) begin
            entries[i] <= '0;
          end else begin
            entries[i] <= shift_in[i];
          end
        end else if (clear_in_place) begin
          entries[i] <= '0;
        end
      end
    end
  endgenerate

endmodule

/* src/head_select_match.sv */
////////////////////////////////////////////////////////////////////////////
// Output stage of the CAM FIFO; presents the oldest word, the pending
// and full flags, and the machine-timer match over valid entries
////////////////////////////////////////////////////////////////////////////
`include "ntrpt_params.svh"

module head_select_match (
  input  fifo_pkg::data_t  entries [`FIFO_DEPTH],
  input  fifo_pkg::count_t count,
  output fifo_pkg::data_t  dout,
  output logic             pndng,
  output logic             full,
  output logic             mtip
);

  logic [`FIFO_DEPTH-1:0] cause_hit;
  fifo_pkg::data_t        head_word;

  // One-hot select by count, OR-reduced into a single word
  always_comb begin
    head_word = '0;
    for (int k = 0; k < `FIFO_DEPTH; k++) begin
      if (count == fifo_pkg::count_t'(k + 1)) begin
        head_word = head_word | entries[k];
      end
    end
  end

  // Timer cause compare, only for entries below the count
  always_comb begin
    for (int k = 0; k < `FIFO_DEPTH; k++) begin
      cause_hit[k] = (count > fifo_pkg::count_t'(k)) &&
                     (ntrpt_pkg::cause_t'(entries[k]) == ntrpt_pkg::cause_t'(`MTIP_CAUSE));
    end
  end

  assign dout  = head_word;
  assign pndng = (count != '0);
  assign full  = (count == fifo_pkg::count_t'(`FIFO_DEPTH));
  assign mtip  = |cause_hit;

endmodule

/* src/ntrpt_cam_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Interrupt CAM FIFO top; connects the occupancy counter, the entry
// store and the head-select stage on a single clock
////////////////////////////////////////////////////////////////////////////
`include "ntrpt_params.svh"

module ntrpt_cam_fifo (
  input  logic            clk,
  input  logic            reset,
  input  logic            push,
  input  logic            pop,
  input  fifo_pkg::data_t din,
  output fifo_pkg::data_t dout,
  output logic            pndng,
  output logic            full,
  output logic            mtip
);

  fifo_pkg::count_t count;
  logic             push_ok;
  logic             pop_ok;
  fifo_pkg::data_t  entries [`FIFO_DEPTH];

  //////////////////////////////////////////////////////////////////////////
  // Occupancy and strobe qualification
  //////////////////////////////////////////////////////////////////////////
  occupancy_counter occupancy_i (
    .clk     (clk),
    .reset   (reset),
    .push    (push),
    .pop     (pop),
    .count   (count),
    .push_ok (push_ok),
    .pop_ok  (pop_ok)
  );

  //////////////////////////////////////////////////////////////////////////
  // Entry storage
  //////////////////////////////////////////////////////////////////////////
  entry_shift_store store_i (
    .clk     (clk),
    .reset   (reset),
    .push_ok (push_ok),
    .pop_ok  (pop_ok),
    .din     (din),
    .count   (count),
    .entries (entries)
  );

  // Outputs are combinational from count and entries
  head_select_match select_i (
    .entries (entries),
    .count   (count),
    .dout    (dout),
    .pndng   (pndng),
    .full    (full),
    .mtip    (mtip)
  );

endmodule

/* bench/fifo_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Output checker of the CAM FIFO testbench; compares the DUT outputs one
// cycle after each trace line and prints one line per finished test
////////////////////////////////////////////////////////////////////////////
module fifo_checker (
  input  logic            clk,
  input  logic            check_en,
  input  logic            flush,
  input  logic [127:0]    test_name,
  input  fifo_pkg::data_t exp_dout,
  input  logic            exp_pndng,
  input  logic            exp_full,
  input  logic            exp_mtip,
  input  fifo_pkg::data_t dout,
  input  logic            pndng,
  input  logic            full,
  input  logic            mtip,
  output int              error_count,
  output int              check_count,
  output int              test_count,
  output logic            summary_done
);
  timeunit 1ns;
  timeprecision 1ps;

  logic            pipe_en = 1'b0;
  logic            pipe_flush = 1'b0;
  logic [127:0]    pipe_name;
  fifo_pkg::data_t pipe_dout;
  logic            pipe_pndng;
  logic            pipe_full;
  logic            pipe_mtip;

  logic [127:0]    current_name = '0;
  int              errors = 0;
  int              checks = 0;
  int              tests = 0;
  int              test_errors = 0;
  int              test_checks = 0;
  logic            done = 1'b0;

  assign error_count  = errors;
  assign check_count  = checks;
  assign test_count   = tests;
  assign summary_done = done;

  task automatic report_test();
    if (test_errors == 0) begin
      $display("PASS  %0s  (%0d lines)", current_name, test_checks);
    end else begin
      $display("FAIL  %0s  (%0d mismatches in %0d lines)", current_name, test_errors,
               test_checks);
    end
    tests++;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic check_word(input string field, input fifo_pkg::data_t expected,
                            input fifo_pkg::data_t actual);
    if (actual !== expected) begin
      $display("MISMATCH %0s %s: expected %h, actual %h", current_name, field, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string field, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %0s %s: expected %b, actual %b", current_name, field, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expectations driven at one edge belong to the outputs after the next
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    pipe_en    <= check_en;
    pipe_flush <= flush;
    pipe_name  <= test_name;
    pipe_dout  <= exp_dout;
    pipe_pndng <= exp_pndng;
    pipe_full  <= exp_full;
    pipe_mtip  <= exp_mtip;
  end

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (pipe_en === 1'b1) begin
      if (current_name != '0 && pipe_name != current_name) begin
        report_test();
      end
      current_name = pipe_name;
      checks++;
      test_checks++;
      check_word("dout", pipe_dout, dout);
      check_flag("pndng", pipe_pndng, pndng);
      check_flag("full", pipe_full, full);
      check_flag("mtip", pipe_mtip, mtip);
    end
    if (pipe_flush === 1'b1 && !done) begin
      if (current_name != '0) begin
        report_test();
      end
      done = 1'b1;
    end
  end

endmodule

/* bench/tb_ntrpt_cam_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench of the interrupt CAM FIFO; replays the trace file against the
// DUT and prints the closing summary
////////////////////////////////////////////////////////////////////////////
module tb_ntrpt_cam_fifo;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES    = 10;
  localparam int RESET_TIMEOUT   = 20;
  localparam int SUMMARY_TIMEOUT = 20;
  localparam int MAX_LINES       = 1000;

  logic            clk;
  logic            reset;
  logic            reset_next;
  logic            push;
  logic            pop;
  fifo_pkg::data_t din;
  fifo_pkg::data_t dout;
  logic            pndng;
  logic            full;
  logic            mtip;

  logic            check_en;
  logic            flush;
  logic [127:0]    test_name;
  fifo_pkg::data_t exp_dout;
  logic            exp_pndng;
  logic            exp_full;
  logic            exp_mtip;
  int              error_count;
  int              check_count;
  int              test_count;
  logic            summary_done;
  int              setup_errors;

  ntrpt_cam_fifo dut_i (
    .clk   (clk),
    .reset (reset),
    .push  (push),
    .pop   (pop),
    .din   (din),
    .dout  (dout),
    .pndng (pndng),
    .full  (full),
    .mtip  (mtip)
  );

  fifo_checker checker_i (
    .clk          (clk),
    .check_en     (check_en),
    .flush        (flush),
    .test_name    (test_name),
    .exp_dout     (exp_dout),
    .exp_pndng    (exp_pndng),
    .exp_full     (exp_full),
    .exp_mtip     (exp_mtip),
    .dout         (dout),
    .pndng        (pndng),
    .full         (full),
    .mtip         (mtip),
    .error_count  (error_count),
    .check_count  (check_count),
    .test_count   (test_count),
    .summary_done (summary_done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic apply_reset();
    int cycles;
    cycles = 0;
    while (cycles < RESET_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    reset <= 1'b0;
    cycles = 0;
    while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (reset !== 1'b0) begin
      $display("Reset was not released in time");
      setup_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One trace line per clock edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_trace(input int fd);
    string           line;
    int              line_no;
    int              fields;
    int              rst_v, push_v, pop_v;
    int              pndng_v, full_v, mtip_v;
    logic [127:0]    name_v;
    fifo_pkg::data_t din_v;
    fifo_pkg::data_t dout_v;
    line_no = 0;
    while (!$feof(fd) && line_no < MAX_LINES) begin
      line_no++;
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      name_v = '0;
      fields = $sscanf(line, "%s %d %d %d %h %h %d %d %d", name_v, rst_v, push_v, pop_v,
                       din_v, dout_v, pndng_v, full_v, mtip_v);
      if (fields != 9) begin
        $display("Trace line %0d could not be read", line_no);
        setup_errors++;
        continue;
      end
      @(posedge clk);
      // Reset is asynchronous and goes out one edge after its line
      // so that it lands on the edge where that line is sampled
      reset      <= reset_next;
      reset_next = (rst_v != 0);
      push       <= (push_v != 0);
      pop        <= (pop_v != 0);
      din        <= din_v;
      test_name  <= name_v;
      exp_dout   <= dout_v;
      exp_pndng  <= (pndng_v != 0);
      exp_full   <= (full_v != 0);
      exp_mtip   <= (mtip_v != 0);
      check_en   <= 1'b1;
    end
  endtask

  task automatic wait_for_summary();
    int waited;
    waited = 0;
    while (summary_done !== 1'b1 && waited < SUMMARY_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (summary_done !== 1'b1) begin
      $display("Timed out waiting for the checker summary");
      setup_errors++;
    end
  endtask

  initial begin
    int fd;
    reset        = 1'b1;
    reset_next   = 1'b0;
    push         = 1'b0;
    pop          = 1'b0;
    din          = '0;
    check_en     = 1'b0;
    flush        = 1'b0;
    test_name    = '0;
    exp_dout     = '0;
    exp_pndng    = 1'b0;
    exp_full     = 1'b0;
    exp_mtip     = 1'b0;
    setup_errors = 0;
    apply_reset();
    fd = $fopen("bench/ntrpt_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file bench/ntrpt_trace.txt");
      setup_errors++;
    end else begin
      run_trace(fd);
      $fclose(fd);
    end
    @(posedge clk);
    reset    <= reset_next;
    push     <= 1'b0;
    pop      <= 1'b0;
    check_en <= 1'b0;
    flush    <= 1'b1;
    wait_for_summary();
    if (check_count == 0) begin
      $display("No trace line was checked");
      setup_errors++;
    end
    $display("Summary: %0d tests, %0d lines checked, %0d mismatches, %0d other failures",
             test_count, check_count, error_count, setup_errors);
    if (error_count == 0 && setup_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* bench/ntrpt_trace.txt */
# test rst push pop din(hex) | expected after the edge: dout(hex) pndng full mtip
# One line per clock edge; the FIFO is empty at the start of each test
order 0 1 0 11110001 11110001 1 0 0
order 0 1 0 11110002 11110001 1 0 0
order 0 1 0 11110003 11110001 1 0 0
order 0 1 0 11110004 11110001 1 0 0
order 0 1 0 11110005 11110001 1 0 0
order 0 0 1 00000000 11110002 1 0 0
order 0 0 1 00000000 11110003 1 0 0
order 0 0 1 00000000 11110004 1 0 0
order 0 0 1 00000000 11110005 1 0 0
order 0 0 1 00000000 00000000 0 0 0
flags 0 1 0 22220001 22220001 1 0 0
flags 0 1 0 22220002 22220001 1 0 0
flags 0 1 0 22220003 22220001 1 0 0
flags 0 1 0 22220004 22220001 1 0 0
flags 0 1 0 22220005 22220001 1 0 0
flags 0 1 0 22220006 22220001 1 0 0
flags 0 1 0 22220007 22220001 1 0 0
flags 0 1 0 22220008 22220001 1 0 0
flags 0 1 0 22220009 22220001 1 0 0
flags 0 1 0 2222000a 22220001 1 0 0
flags 0 1 0 2222000b 22220001 1 0 0
flags 0 1 0 2222000c 22220001 1 0 0
flags 0 1 0 2222000d 22220001 1 0 0
flags 0 1 0 2222000e 22220001 1 0 0
flags 0 1 0 2222000f 22220001 1 0 0
flags 0 1 0 22220010 22220001 1 1 0
flags 0 1 0 2222ffff 22220001 1 1 0
flags 0 0 1 00000000 22220002 1 0 0
flags 0 0 1 00000000 22220003 1 0 0
flags 0 0 1 00000000 22220004 1 0 0
flags 0 0 1 00000000 22220005 1 0 0
flags 0 0 1 00000000 22220006 1 0 0
flags 0 0 1 00000000 22220007 1 0 0
flags 0 0 1 00000000 22220008 1 0 0
flags 0 0 1 00000000 22220009 1 0 0
flags 0 0 1 00000000 2222000a 1 0 0
flags 0 0 1 00000000 2222000b 1 0 0
flags 0 0 1 00000000 2222000c 1 0 0
flags 0 0 1 00000000 2222000d 1 0 0
flags 0 0 1 00000000 2222000e 1 0 0
flags 0 0 1 00000000 2222000f 1 0 0
flags 0 0 1 00000000 22220010 1 0 0
flags 0 0 1 00000000 00000000 0 0 0
empty_pop 0 0 1 00000000 00000000 0 0 0
empty_pop 0 1 0 33330001 33330001 1 0 0
empty_pop 0 0 1 00000000 00000000 0 0 0
push_pop 0 1 0 44440001 44440001 1 0 0
push_pop 0 1 0 44440002 44440001 1 0 0
push_pop 0 1 1 44440003 44440002 1 0 0
push_pop 0 1 1 44440004 44440003 1 0 0
push_pop 0 0 1 00000000 44440004 1 0 0
push_pop 0 0 1 00000000 00000000 0 0 0
timer 0 1 0 55550001 55550001 1 0 0
timer 0 1 0 55550080 55550001 1 0 1
timer 0 1 0 55550002 55550001 1 0 1
timer 0 0 1 00000000 55550080 1 0 1
timer 0 0 1 00000000 55550002 1 0 0
timer 0 1 0 00805555 55550002 1 0 0
timer 0 0 1 00000000 00805555 1 0 0
timer 0 0 1 00000000 00000000 0 0 0
reset 0 1 0 66660001 66660001 1 0 0
reset 0 1 0 66660080 66660001 1 0 1
reset 0 1 0 66660002 66660001 1 0 1
reset 1 0 0 00000000 00000000 0 0 0
reset 0 0 0 00000000 00000000 0 0 0
reset 0 1 0 66660003 66660003 1 0 0

/* compile.f */
+incdir+src
src/fifo_pkg.sv
src/ntrpt_pkg.sv
src/occupancy_counter.sv
src/entry_shift_store.sv
src/head_select_match.sv
src/ntrpt_cam_fifo.sv
bench/fifo_checker.sv
bench/tb_ntrpt_cam_fifo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CAM FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_ntrpt_cam_fifo -f compile.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -x "Finished with errors" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q -x "Finished with no errors" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
